// File: include/stripe_cfg.svh
`ifndef STRIPE_CFG_SVH
`define STRIPE_CFG_SVH

// number of banks the upstream space is striped over, must be a power of two
`define STRIPE_NUM_S 4

// upstream byte address width
`define STRIPE_ADDR_W 12

// data width of every channel, the strobe carries one bit per byte
`define STRIPE_DATA_W 32

// transaction id width
`define STRIPE_ID_W 4

// words held by one bank
// the upstream word space is split evenly, so drop the byte and bank select bits
`define STRIPE_BANK_WORDS \
  (1 << (`STRIPE_ADDR_W - $clog2(`STRIPE_DATA_W / 8) - $clog2(`STRIPE_NUM_S)))

`endif

// File: source/axi_pkg.sv
package axi_pkg;

  // burst encodings as carried on awburst
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // write response codes as carried on bresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

// File: source/stripe_pkg.sv
`include "stripe_cfg.svh"

package stripe_pkg;

  // selects one bank, taken from the low word address bits
  typedef logic [$clog2(`STRIPE_NUM_S)-1:0] bank_idx_t;

  // address as seen inside one bank
  // the bank select bits are gone, so it is narrower than the upstream address
  typedef logic [`STRIPE_ADDR_W-$clog2(`STRIPE_NUM_S)-1:0] bank_addr_t;

  // write state of a bank memory
  typedef enum logic [1:0] {
    IDLE,
    DATA,
    RESP
  } bank_state_e;

endpackage

// File: source/axi_wr_if.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

// write channels between the stripe splitter and one bank
interface axi_wr_if;

  // aw channel
  logic                      awvalid;
  stripe_pkg::bank_addr_t    awaddr;
  logic [`STRIPE_ID_W-1:0]   awid;
  logic [7:0]                awlen;
  logic [2:0]                awsize;
  axi_pkg::axi_burst_e       awburst;
  logic                      awready;

  // w channel
  logic                      wvalid;
  logic [`STRIPE_DATA_W-1:0] wdata;
  logic [`STRIPE_DATA_W/8-1:0] wstrb;
  logic                      wlast;
  logic                      wready;

  // b channel
  logic                      bvalid;
  logic [`STRIPE_ID_W-1:0]   bid;
  axi_pkg::axi_resp_e        bresp;
  logic                      bready;

  modport mgr (
    output awvalid, awaddr, awid, awlen, awsize, awburst, wvalid, wdata, wstrb, wlast, bready,
    input  awready, wready, bvalid, bid, bresp
  );

  modport sub (
    input  awvalid, awaddr, awid, awlen, awsize, awburst, wvalid, wdata, wstrb, wlast, bready,
    output awready, wready, bvalid, bid, bresp
  );

endinterface

// File: source/stripe_wr.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

// splits one upstream write burst into one sub-burst per bank
// caller rules: stripe aligned address, full word size, whole stripes, INCR only
module stripe_wr import axi_pkg::*, stripe_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          aw_valid,
  input  logic [`STRIPE_ADDR_W-1:0]     aw_addr,
  input  logic [`STRIPE_ID_W-1:0]       aw_id,
  input  logic [7:0]                    aw_len,
  input  logic [2:0]                    aw_size,
  input  axi_burst_e                    aw_burst,
  output logic                          aw_ready,
  input  logic                          w_valid,
  input  logic [`STRIPE_DATA_W-1:0]     w_data,
  input  logic [`STRIPE_DATA_W/8-1:0]   w_strb,
  input  logic                          w_last,
  output logic                          w_ready,
  output logic                          b_valid,
  output logic [`STRIPE_ID_W-1:0]       b_id,
  output axi_resp_e                     b_resp,
  input  logic                          b_ready,
  axi_wr_if.mgr                         banks [`STRIPE_NUM_S-1:0]
);
  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int S_W = $clog2(NUM_S);
  localparam int B_W = $clog2(`STRIPE_DATA_W / 8);

  logic aw_xfer;
  logic w_xfer;
  logic b_xfer;

  // per bank handshake status gathered from the interface array
  logic [NUM_S-1:0] bank_awready;
  logic [NUM_S-1:0] bank_wready;
  logic [NUM_S-1:0] bank_bvalid;

  logic [NUM_S-1:0] awvalid_q;
  logic [NUM_S-1:0] aw_done;
  logic [NUM_S-1:0] b_done;
  logic [NUM_S-1:0] b_done_next;
  logic [NUM_S-1:0] wvalid_q;
  logic [NUM_S-1:0] wlast_q;
  logic [NUM_S-1:0][`STRIPE_DATA_W-1:0] wdata_q;
  logic [NUM_S-1:0][`STRIPE_DATA_W/8-1:0] wstrb_q;

  // aw payload is the same for every bank, so one copy is kept
  bank_addr_t              aw_addr_q;
  logic [`STRIPE_ID_W-1:0] aw_id_q;
  logic [7:0]              aw_len_q;
  logic [2:0]              aw_size_q;
  axi_burst_e              aw_burst_q;

  bank_idx_t  lane;
  logic [7:0] stripes_todo;
  logic       w_busy;

  assign aw_xfer = aw_valid && aw_ready;
  assign w_xfer  = w_valid && w_ready;
  assign b_xfer  = b_valid && b_ready;

  // ----------------------------------------------------------
  // bank fan out
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_S; i++) begin : gen_bank
    assign banks[i].awvalid = awvalid_q[i];
    assign banks[i].awaddr  = aw_addr_q;
    assign banks[i].awid    = aw_id_q;
    assign banks[i].awlen   = aw_len_q;
    assign banks[i].awsize  = aw_size_q;
    assign banks[i].awburst = aw_burst_q;
    assign banks[i].wvalid  = wvalid_q[i];
    assign banks[i].wdata   = wdata_q[i];
    assign banks[i].wstrb   = wstrb_q[i];
    assign banks[i].wlast   = wlast_q[i];
    // responses are buffered here, so a bank never waits on b
    assign banks[i].bready  = 1'b1;
    assign bank_awready[i]  = banks[i].awready;
    assign bank_wready[i]   = banks[i].wready;
    assign bank_bvalid[i]   = banks[i].bvalid;
  end

  // ----------------------------------------------------------
  // aw channel
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready  <= 1'b1;
      awvalid_q <= '0;
      aw_done   <= '0;
    end else begin
      // one burst in flight, the next address waits for the upstream response
      if (b_xfer) begin
        aw_ready <= 1'b1;
      end
      if (aw_xfer) begin
        aw_ready <= 1'b0;
      end
      awvalid_q <= aw_xfer ? '1 : (awvalid_q & ~bank_awready);
      aw_done   <= b_xfer ? '0 : (aw_done | (awvalid_q & bank_awready));
    end
  end

  // the bank address drops the bank select bits of the word address
  // the byte bits stay zero because the burst is stripe aligned
  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      aw_addr_q  <= {aw_addr[`STRIPE_ADDR_W-1:S_W+B_W], B_W'(0)};
      aw_id_q    <= aw_id;
      aw_len_q   <= aw_len >> S_W;
      aw_size_q  <= aw_size;
      aw_burst_q <= aw_burst;
    end
  end

  // ----------------------------------------------------------
  // lane and stripe tracking
  // ----------------------------------------------------------
  // the lane wraps by itself since the bank count is a power of two
  // wlast goes out on every beat of the final stripe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane         <= '0;
      stripes_todo <= '0;
      w_busy       <= 1'b0;
    end else if (aw_xfer) begin
      lane         <= '0;
      stripes_todo <= aw_len >> S_W;
      w_busy       <= 1'b1;
    end else if (w_xfer) begin
      lane <= lane + 1'b1;
      if (lane == '1) begin
        stripes_todo <= stripes_todo - 1'b1;
      end
      if (w_last) begin
        w_busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // w channel
  // ----------------------------------------------------------
  // a stalled bank holds its beat, and the upstream stalls with it
  assign w_ready = w_busy && aw_done[lane] && bank_wready[lane];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wvalid_q <= '0;
    end else begin
      for (int i = 0; i < NUM_S; i++) begin
        wvalid_q[i] <= (wvalid_q[i] && !bank_wready[i]) || (w_xfer && lane == bank_idx_t'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_S; i++) begin
      if (w_xfer && lane == bank_idx_t'(i)) begin
        wdata_q[i] <= w_data;
        wstrb_q[i] <= w_strb;
        wlast_q[i] <= (stripes_todo == 8'd0);
      end
    end
  end

  // ----------------------------------------------------------
  // b channel
  // ----------------------------------------------------------
  // every bank answers once per burst, the upstream answer waits for all of them
  assign b_done_next = b_xfer ? '0 : (b_done | bank_bvalid);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done  <= '0;
      b_valid <= 1'b0;
    end else begin
      b_done  <= b_done_next;
      b_valid <= &b_done_next;
    end
  end

  // id and response come from bank 0, all banks see the same burst
  always_ff @(posedge clk) begin
    if (bank_bvalid[0]) begin
      b_id   <= banks[0].bid;
      b_resp <= banks[0].bresp;
    end
  end

endmodule

// File: source/axi_bank_mem.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

// one bank of the striped space, a write subordinate over a word array
module axi_bank_mem import axi_pkg::*, stripe_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  axi_wr_if.sub                     port,
  input  bank_addr_t                rd_word,
  output logic [`STRIPE_DATA_W-1:0] rd_data
);
  localparam int WORDS = `STRIPE_BANK_WORDS;
  localparam int WORD_W = $clog2(WORDS);
  localparam int B_W = $clog2(`STRIPE_DATA_W / 8);
  localparam int BA_W = $bits(bank_addr_t);

  logic [`STRIPE_DATA_W-1:0] mem [WORDS];

  bank_state_e             state;
  logic [WORD_W-1:0]       wptr;
  logic [`STRIPE_ID_W-1:0] bid_q;
  axi_burst_e              burst_q;

  logic w_xfer;

  assign port.awready = (state == IDLE);
  assign port.wready  = (state == DATA);
  assign port.bvalid  = (state == RESP);
  assign port.bid     = bid_q;
  assign port.bresp   = OKAY;

  assign w_xfer = port.wvalid && port.wready;

  // ----------------------------------------------------------
  // write state
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (port.awvalid) state <= DATA;
        DATA: if (w_xfer && port.wlast) state <= RESP;
        RESP: if (port.bready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // the pointer starts at the word the bank address names
  // and steps once per beat of an incr burst
  always_ff @(posedge clk) begin
    if (port.awvalid && port.awready) begin
      wptr    <= port.awaddr[BA_W-1:B_W];
      bid_q   <= port.awid;
      burst_q <= port.awburst;
    end else if (w_xfer && burst_q == INCR) begin
      wptr <= wptr + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // array
  // ----------------------------------------------------------
  // only the bytes with their strobe set are written
  always_ff @(posedge clk) begin
    if (w_xfer) begin
      for (int b = 0; b < `STRIPE_DATA_W / 8; b++) begin
        if (port.wstrb[b]) begin
          mem[wptr][8*b +: 8] <= port.wdata[8*b +: 8];
        end
      end
    end
  end

  // read port for the readback block, upper index bits are always zero
  assign rd_data = mem[rd_word[WORD_W-1:0]];

endmodule

// File: source/stripe_readback.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

// single word readback across the striped space
module stripe_readback import stripe_pkg::*; (
  input  logic                                          clk,
  input  logic [`STRIPE_ADDR_W-1:0]                     rd_addr,
  output bank_addr_t                                    bank_word,
  input  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0]  bank_data,
  output logic [`STRIPE_DATA_W-1:0]                     rd_data
);
  localparam int S_W = $clog2(`STRIPE_NUM_S);
  localparam int B_W = $clog2(`STRIPE_DATA_W / 8);

  bank_idx_t bank_sel;
  bank_idx_t bank_sel_q;
  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] bank_data_q;

  // low word address bits pick the bank, the rest is the word inside it
  assign bank_sel  = rd_addr[B_W +: S_W];
  assign bank_word = bank_addr_t'(rd_addr[`STRIPE_ADDR_W-1:B_W+S_W]);

  // every bank reads the same word, the registered index picks one of them
  always_ff @(posedge clk) begin
    bank_sel_q  <= bank_sel;
    bank_data_q <= bank_data;
  end

  assign rd_data = bank_data_q[bank_sel_q];

endmodule

// File: source/stripe_top.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

// striped write path with its bank memories and a readback port
module stripe_top import axi_pkg::*, stripe_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          aw_valid,
  input  logic [`STRIPE_ADDR_W-1:0]     aw_addr,
  input  logic [`STRIPE_ID_W-1:0]       aw_id,
  input  logic [7:0]                    aw_len,
  input  logic [2:0]                    aw_size,
  input  axi_burst_e                    aw_burst,
  output logic                          aw_ready,
  input  logic                          w_valid,
  input  logic [`STRIPE_DATA_W-1:0]     w_data,
  input  logic [`STRIPE_DATA_W/8-1:0]   w_strb,
  input  logic                          w_last,
  output logic                          w_ready,
  output logic                          b_valid,
  output logic [`STRIPE_ID_W-1:0]       b_id,
  output axi_resp_e                     b_resp,
  input  logic                          b_ready,
  input  logic [`STRIPE_ADDR_W-1:0]     rd_addr,
  output logic [`STRIPE_DATA_W-1:0]     rd_data
);
  axi_wr_if bank_if [`STRIPE_NUM_S-1:0] ();

  bank_addr_t                                   bank_word;
  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] bank_rd;

  stripe_wr u_stripe_wr (
    .clk, .rst_n,
    .aw_valid, .aw_addr, .aw_id, .aw_len, .aw_size, .aw_burst, .aw_ready,
    .w_valid, .w_data, .w_strb, .w_last, .w_ready,
    .b_valid, .b_id, .b_resp, .b_ready,
    .banks (bank_if)
  );

  for (genvar i = 0; i < `STRIPE_NUM_S; i++) begin : gen_mem
    axi_bank_mem u_bank (
      .clk, .rst_n,
      .port    (bank_if[i]),
      .rd_word (bank_word),
      .rd_data (bank_rd[i])
    );
  end

  stripe_readback u_readback (
    .clk,
    .rd_addr,
    .bank_word,
    .bank_data (bank_rd),
    .rd_data
  );

endmodule

// File: verification/stripe_tb.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_tb import axi_pkg::*;;
  localparam int NUM_S  = `STRIPE_NUM_S;
  localparam int ADDR_W = `STRIPE_ADDR_W;
  localparam int DATA_W = `STRIPE_DATA_W;
  localparam int STRB_W = `STRIPE_DATA_W / 8;
  localparam int ID_W   = `STRIPE_ID_W;

  // bursts land in a small region so that later strobes overlap older data
  localparam int STRIPE_BYTES   = NUM_S * STRB_W;
  localparam int REGION_STRIPES = 32;
  localparam int REGION_BYTES   = REGION_STRIPES * STRIPE_BYTES;

  // three phases of bursts, plus room for reset and the final sweep
  localparam int PHASE_BURSTS     = 10;
  localparam int CYCLES_PER_BURST = 64;
  localparam int TIMEOUT_CYCLES   = (3 * PHASE_BURSTS + 10) * CYCLES_PER_BURST;

  logic                clk;
  logic                rst_n;
  logic                aw_valid;
  logic [ADDR_W-1:0]   aw_addr;
  logic [ID_W-1:0]     aw_id;
  logic [7:0]          aw_len;
  logic [2:0]          aw_size;
  axi_burst_e          aw_burst;
  logic                aw_ready;
  logic                w_valid;
  logic [DATA_W-1:0]   w_data;
  logic [STRB_W-1:0]   w_strb;
  logic                w_last;
  logic                w_ready;
  logic                b_valid;
  logic [ID_W-1:0]     b_id;
  axi_resp_e           b_resp;
  logic                b_ready;
  logic [ADDR_W-1:0]   rd_addr;
  logic [DATA_W-1:0]   rd_data;

  // byte shadow of the striped space, with a flag for bytes that were written
  logic [7:0] shadow [REGION_BYTES];
  bit         written [REGION_BYTES];

  logic [31:0]     rand_state;
  int              errors;
  int              checks;
  int              cycles;
  int              bursts;
  int              b_count;
  bit              in_flight;
  logic            b_valid_prev;
  logic [ID_W-1:0] exp_id;

  stripe_top u_stripe_top (
    .clk, .rst_n,
    .aw_valid, .aw_addr, .aw_id, .aw_len, .aw_size, .aw_burst, .aw_ready,
    .w_valid, .w_data, .w_strb, .w_last, .w_ready,
    .b_valid, .b_id, .b_resp, .b_ready,
    .rd_addr, .rd_data
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  // plain LCG whose upper bits are the better ones so callers shift down
  function logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function int rand_below(input int n);
    return int'((next_rand() >> 8) % 32'(n));
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // every strobed byte of a beat lands at its own byte address
  function void update_model(input int addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        shadow[addr + b]  = data[8*b +: 8];
        written[addr + b] = 1'b1;
      end
    end
  endfunction

  // bytes never written are masked out since the bank array holds no known value there
  task automatic read_check(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < STRB_W; b++) begin
      exp[8*b +: 8]  = shadow[int'(addr) + b];
      mask[8*b +: 8] = {8{written[int'(addr) + b]}};
    end
    @(posedge clk);
    rd_addr <= addr;
    // one cycle of read latency, then sample away from the edge
    @(posedge clk);
    @(negedge clk);
    check_equal(rd_data & mask, exp & mask, $sformatf("readback at %h", addr));
  endtask

  // ------------------------------------------------------------
  // one upstream write burst, then a readback of every beat
  // ------------------------------------------------------------
  task automatic write_burst(input int n_stripes, input bit rand_strb, input bit stall);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int                beats;
    beats = n_stripes * NUM_S;
    addr  = ADDR_W'(rand_below(REGION_STRIPES - n_stripes + 1) * STRIPE_BYTES);
    bursts++;

    @(posedge clk);
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    aw_id    <= ID_W'(rand_below(1 << ID_W));
    aw_len   <= 8'(beats - 1);
    aw_size  <= 3'($clog2(STRB_W));
    aw_burst <= INCR;
    // ready is decided on the negedge before the transfer edge
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    @(posedge clk);
    aw_valid <= 1'b0;

    for (int k = 0; k < beats; k++) begin
      if (stall) begin
        repeat (rand_below(3)) begin
          w_valid <= 1'b0;
          @(posedge clk);
        end
      end
      data = next_rand();
      strb = rand_strb ? STRB_W'(next_rand() >> 8) : '1;
      w_valid <= 1'b1;
      w_data  <= data;
      w_strb  <= strb;
      w_last  <= (k == beats - 1);
      @(negedge clk);
      while (!w_ready) @(negedge clk);
      @(posedge clk);
      update_model(int'(addr) + STRB_W * k, data, strb);
    end
    w_valid <= 1'b0;
    w_last  <= 1'b0;

    // hold b_ready low for a while so the response has to wait
    if (stall) begin
      repeat (rand_below(8)) @(posedge clk);
    end
    b_ready <= 1'b1;
    @(negedge clk);
    while (!b_valid) @(negedge clk);
    @(posedge clk);
    b_ready <= 1'b0;

    for (int k = 0; k < beats; k++) begin
      read_check(addr + ADDR_W'(STRB_W * k));
    end
  endtask

  // ------------------------------------------------------------
  // monitors
  // ------------------------------------------------------------
  // tracks the open burst between its AW and B transfers
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_flight) begin
        check_equal(32'(aw_ready), 32'd0, "aw_ready high while a burst is open");
      end
      if (b_valid && !in_flight) begin
        check_equal(32'(b_valid), 32'd0, "b_valid with no open burst");
      end
      // a response that drops before its transfer and rises again counts twice
      if (b_valid && !b_valid_prev) begin
        b_count++;
      end
      b_valid_prev = b_valid;
      if (aw_valid && aw_ready) begin
        in_flight = 1'b1;
        exp_id    = aw_id;
      end
      if (b_valid && b_ready) begin
        check_equal(32'(b_id), 32'(exp_id), "b_id");
        check_equal(32'(b_resp), 32'(OKAY), "b_resp");
        in_flight = 1'b0;
      end
    end
  end

  // a stuck bank or handshake ends the run here
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("summary: %0d checks, %0d errors", checks, errors);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    rand_state   = 32'hf8fc;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    bursts       = 0;
    b_count      = 0;
    in_flight    = 1'b0;
    b_valid_prev = 1'b0;
    exp_id       = '0;
    for (int i = 0; i < REGION_BYTES; i++) begin
      shadow[i]  = 8'h00;
      written[i] = 1'b0;
    end
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw_addr  = '0;
    aw_id    = '0;
    aw_len   = '0;
    aw_size  = '0;
    aw_burst = INCR;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    b_ready  = 1'b0;
    rd_addr  = '0;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // single stripes check the beat to bank placement
    for (int i = 0; i < PHASE_BURSTS; i++) begin
      write_burst(1, 1'b0, 1'b0);
    end
    // longer bursts need the right wlast on the final stripe
    for (int i = 0; i < PHASE_BURSTS; i++) begin
      write_burst(2 + rand_below(3), 1'b0, 1'b0);
    end
    // partial strobes, w_valid gaps and b_ready stalls together
    for (int i = 0; i < PHASE_BURSTS; i++) begin
      write_burst(1 + rand_below(4), 1'b1, 1'b1);
    end

    // sweep the whole region once more after all writes
    for (int a = 0; a < REGION_BYTES; a += STRB_W) begin
      read_check(ADDR_W'(a));
    end
    repeat (4) @(posedge clk);
    check_equal(32'(b_count), 32'(bursts), "response count");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
source/axi_pkg.sv
source/stripe_pkg.sv
source/axi_wr_if.sv
source/stripe_wr.sv
source/axi_bank_mem.sv
source/stripe_readback.sv
source/stripe_top.sv
verification/stripe_tb.sv

// File: Makefile
TOP = stripe_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# the run passes only when the pass message shows up in the output
sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
